/* rtl/esaxi_defs.svh */
`ifndef ESAXI_DEFS_SVH
`define ESAXI_DEFS_SVH

// ########################################
// axi side
// ########################################

// address and data width
`define ESAXI_AW 32
`define ESAXI_DW 32

// ########################################
// mesh side
// ########################################

// full emesh packet width
`define ESAXI_PW 104

// node 12'h999 with read-response group 4'hd
`define ESAXI_RETURN_ADDR 16'h999d

// read timeout counter width, short for sim
`define ESAXI_TW 8

// word handed back when the mesh never answers
`define ESAXI_TIMEOUT_DATA 32'hdeadbeef

`endif

/* rtl/esaxi_pkg.sv */
`include "esaxi_defs.svh"

package esaxi_pkg;

   // ########################################
   // plain vectors
   // ########################################

   typedef logic [`ESAXI_AW-1:0]   addr_t;     // axi / mesh address
   typedef logic [`ESAXI_DW-1:0]   data_t;     // one data word
   typedef logic [`ESAXI_DW/8-1:0] strb_t;     // byte lanes
   typedef logic [2:0]             size_t;     // axi size code
   typedef logic [1:0]             datamode_t; // low bits of size
   typedef logic [4:0]             ctrlmode_t; // unused by this bridge
   typedef logic [`ESAXI_PW-1:0]   packet_t;   // raw mesh packet
   typedef logic [`ESAXI_TW-1:0]   tcount_t;   // read timeout count

   // packet layout, msb first
   typedef struct packed {
      addr_t     srcaddr;   // 103:72
      data_t     data;      // 71:40
      addr_t     dstaddr;   // 39:8
      ctrlmode_t ctrlmode;  // 7:3
      datamode_t datamode;  // 2:1
      logic      write;     // 0
   } packet_fields_t;

   // ########################################
   // read timeout fsm
   // ########################################

   typedef enum logic [1:0] {
      TO_IDLE,     // no read pending
      TO_ARMED,    // request out, counting down
      TO_EXPIRED   // one cycle, fake response
   } timeout_state_e;

endpackage

/* rtl/esaxi_req_if.sv */
// request side of the bridge
// ctrl decodes the axi handshakes, the packers just follow
interface esaxi_req_if;

   // write path
   logic             wr_beat;  // w handshake this cycle
   esaxi_pkg::addr_t wr_addr;  // held from aw
   esaxi_pkg::size_t wr_size;  // held from aw

   // read path
   logic             rd_start; // ar handshake this cycle
   esaxi_pkg::addr_t rd_addr;  // held from ar
   esaxi_pkg::size_t rd_size;  // held from ar, also used on return

   modport ctrl
   (
      output wr_beat,
      output wr_addr,
      output wr_size,
      output rd_start,
      output rd_addr,
      output rd_size
   );

   // write packet builder
   modport wr
   (
      input  wr_beat,
      input  wr_addr,
      input  wr_size
   );

   // read request builder and response path
   modport rd
   (
      input  rd_start,
      input  rd_addr,
      input  rd_size
   );

endinterface

/* rtl/esaxi_ctrl.sv */
module esaxi_ctrl
(
   input  logic             s_axi_aclk,
   input  logic             s_axi_aresetn,
   input  logic             awvalid,
   input  logic             wvalid,
   input  logic             bready,
   input  logic             arvalid,
   input  esaxi_pkg::addr_t awaddr,
   input  esaxi_pkg::addr_t araddr,
   input  esaxi_pkg::size_t awsize,
   input  esaxi_pkg::size_t arsize,
   input  logic             txwr_wait,   // mesh tx fifo full
   input  logic             rd_done,     // r handshake from return path
   output logic             awready,
   output logic             wready,
   output logic             bvalid,
   output logic             arready,
   esaxi_req_if.ctrl        req
);

   logic write_active; // aw taken, w not yet
   logic read_active;  // ar taken, r not yet
   logic aw_hs;
   logic w_hs;
   logic ar_hs;

   assign aw_hs = awvalid & awready;
   assign w_hs  = wvalid & wready;
   assign ar_hs = arvalid & arready;

   assign req.wr_beat  = w_hs;
   assign req.rd_start = ar_hs;

   // ########################################
   // write side
   // ########################################

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         awready      <= 1'b1;  // ready for an address out of reset
         write_active <= 1'b0;
         wready       <= 1'b0;
         bvalid       <= 1'b0;
      end
      else
      begin
         // next address only once b is gone
         if (bvalid & bready)
            awready <= 1'b1;
         else if (aw_hs)
            awready <= 1'b0;

         if (aw_hs)
            write_active <= 1'b1;
         else if (w_hs)
            write_active <= 1'b0;

         // single beat, so drop right after it
         if (w_hs)
            wready <= 1'b0;
         else if (write_active)
            wready <= ~txwr_wait; // mesh backpressure

         if (w_hs)
            bvalid <= 1'b1;       // always okay
         else if (bready)
            bvalid <= 1'b0;
      end
   end

   // ########################################
   // read side
   // ########################################

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         arready     <= 1'b0;
         read_active <= 1'b0;
      end
      else
      begin
         // one read in flight, mesh may reorder
         if (!arready && !read_active)
            arready <= 1'b1;
         else if (ar_hs)
            arready <= 1'b0;

         if (ar_hs)
            read_active <= 1'b1;
         else if (rd_done)
            read_active <= 1'b0;
      end
   end

   // address capture
   always_ff @(posedge s_axi_aclk)
   begin
      if (aw_hs)
      begin
         req.wr_addr <= awaddr;
         req.wr_size <= awsize; // 0 byte, 1 half, 2 word
      end
      if (ar_hs)
      begin
         req.rd_addr <= araddr;
         req.rd_size <= arsize;
      end
   end

   a_wready_in_write: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
      wready |-> write_active);

   a_arready_blocked: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
      read_active |-> !arready);

endmodule

/* rtl/txwr_packer.sv */
`include "esaxi_defs.svh"

module txwr_packer
(
   input  logic                s_axi_aclk,
   input  logic                s_axi_aresetn,
   input  esaxi_pkg::data_t    wdata,
   input  esaxi_pkg::strb_t    wstrb,
   esaxi_req_if.wr             req,
   output logic                txwr_access,
   output esaxi_pkg::packet_t  txwr_packet
);

   logic [1:0]                byte_ofs;     // lowest active lane
   esaxi_pkg::data_t          data_aligned;
   logic                      pre_access;   // stage 1 valid
   esaxi_pkg::data_t          data_q;
   esaxi_pkg::addr_t          dstaddr_q;
   esaxi_pkg::datamode_t      datamode_q;
   esaxi_pkg::packet_fields_t fields;

   // first set strobe wins
   always_comb
   begin
      casez (wstrb)
         4'b???1: byte_ofs = 2'd0;
         4'b??10: byte_ofs = 2'd1;
         4'b?100: byte_ofs = 2'd2;
         default: byte_ofs = 2'd3;
      endcase
   end

   assign data_aligned = wdata >> {byte_ofs, 3'b000}; // mesh wants data at bit 0

   // ########################################
   // two stage pipe
   // ########################################

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         pre_access  <= 1'b0;
         txwr_access <= 1'b0;
      end
      else
      begin
         pre_access  <= req.wr_beat;
         txwr_access <= pre_access;
      end
   end

   always_comb
   begin
      fields.srcaddr  = '0;      // no response for writes
      fields.data     = data_q;
      fields.dstaddr  = dstaddr_q;
      fields.ctrlmode = '0;
      fields.datamode = datamode_q;
      fields.write    = 1'b1;
   end

   always_ff @(posedge s_axi_aclk)
   begin
      if (req.wr_beat)
      begin
         data_q     <= data_aligned;
         dstaddr_q  <= {req.wr_addr[`ESAXI_AW-1:2], byte_ofs}; // lsbs from strobes
         datamode_q <= req.wr_size[1:0];
      end
      if (pre_access)
         txwr_packet <= fields; // lands with txwr_access
   end

endmodule

/* rtl/txrd_packer.sv */
`include "esaxi_defs.svh"

module txrd_packer
(
   input  logic                s_axi_aclk,
   input  logic                s_axi_aresetn,
   esaxi_req_if.rd             req,
   output logic                txrd_access,
   output esaxi_pkg::packet_t  txrd_packet
);

   logic                      rd_pend;  // stage 1 of the request
   esaxi_pkg::packet_fields_t fields;

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         rd_pend     <= 1'b0;
         txrd_access <= 1'b0;
      end
      else
      begin
         rd_pend     <= req.rd_start;
         txrd_access <= rd_pend;
      end
   end

   // read request, response comes back to our node
   always_comb
   begin
      fields.srcaddr  = {`ESAXI_RETURN_ADDR, 16'h0000};
      fields.data     = '0;
      fields.dstaddr  = req.rd_addr;
      fields.ctrlmode = '0;
      fields.datamode = req.rd_size[1:0];
      fields.write    = 1'b0;
   end

   always_ff @(posedge s_axi_aclk)
   begin
      if (rd_pend)
         txrd_packet <= fields;
   end

endmodule

/* rtl/rxrr_return.sv */
`include "esaxi_defs.svh"

module rxrr_return
(
   input  logic                s_axi_aclk,
   input  logic                s_axi_aresetn,
   input  logic                rxrr_access,
   input  esaxi_pkg::packet_t  rxrr_packet,
   input  logic                rready,
   esaxi_req_if.rd             req,
   output logic                rvalid,
   output esaxi_pkg::data_t    rdata,
   output logic                rd_done
);

   esaxi_pkg::timeout_state_e state;
   esaxi_pkg::tcount_t        tcount;
   esaxi_pkg::packet_fields_t rx_fields;
   esaxi_pkg::data_t          ret_word;
   logic                      cnt_zero;
   logic                      resp_take;
   logic                      ret_event;

   assign rx_fields = rxrr_packet;        // only data is used
   assign cnt_zero  = (tcount == '0);
   assign resp_take = rxrr_access & (state == esaxi_pkg::TO_ARMED); // late ones dropped
   assign ret_event = resp_take | (state == esaxi_pkg::TO_EXPIRED);
   assign ret_word  = (state == esaxi_pkg::TO_EXPIRED) ? `ESAXI_TIMEOUT_DATA : rx_fields.data;
   assign rd_done   = rvalid & rready;

   // ########################################
   // timeout
   // ########################################

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         state  <= esaxi_pkg::TO_IDLE;
         tcount <= '1;
      end
      else
      begin
         if (req.rd_start)
            tcount <= '1;             // full window per read
         else if (state == esaxi_pkg::TO_ARMED && !cnt_zero)
            tcount <= tcount - 1'b1;

         case (state)
            esaxi_pkg::TO_IDLE:
               if (req.rd_start)
                  state <= esaxi_pkg::TO_ARMED;
            esaxi_pkg::TO_ARMED:
               if (rxrr_access)
                  state <= esaxi_pkg::TO_IDLE;
               else if (cnt_zero)
                  state <= esaxi_pkg::TO_EXPIRED;
            default:
               state <= esaxi_pkg::TO_IDLE; // expired lasts one cycle
         endcase
      end
   end

   // ########################################
   // r channel
   // ########################################

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
         rvalid <= 1'b0;
      else if (ret_event)
         rvalid <= 1'b1;
      else if (rready)
         rvalid <= 1'b0;              // held until taken
   end

   // narrow reads replicated across the bus
   always_ff @(posedge s_axi_aclk)
   begin
      if (ret_event)
      begin
         case (req.rd_size[1:0])
            2'b00:   rdata <= {4{ret_word[7:0]}};
            2'b01:   rdata <= {2{ret_word[15:0]}};
            default: rdata <= ret_word;
         endcase
      end
   end

   a_no_resp_on_expiry: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
      !(state == esaxi_pkg::TO_EXPIRED && rxrr_access));

endmodule

/* rtl/esaxi.sv */
module esaxi
(
   input  logic               s_axi_aclk,
   input  logic               s_axi_aresetn,
   // aw
   input  esaxi_pkg::addr_t   awaddr,
   input  esaxi_pkg::size_t   awsize,
   input  logic               awvalid,
   output logic               awready,
   // w
   input  esaxi_pkg::data_t   wdata,
   input  esaxi_pkg::strb_t   wstrb,
   input  logic               wvalid,
   output logic               wready,
   // b
   output logic               bvalid,
   input  logic               bready,
   // ar
   input  esaxi_pkg::addr_t   araddr,
   input  esaxi_pkg::size_t   arsize,
   input  logic               arvalid,
   output logic               arready,
   // r
   output esaxi_pkg::data_t   rdata,
   output logic               rvalid,
   input  logic               rready,
   // mesh
   output logic               txwr_access,
   output esaxi_pkg::packet_t txwr_packet,
   input  logic               txwr_wait,
   output logic               txrd_access,
   output esaxi_pkg::packet_t txrd_packet,
   input  logic               rxrr_access,
   input  esaxi_pkg::packet_t rxrr_packet
);

   logic rd_done;

   esaxi_req_if req ();

   esaxi_ctrl ctrl0 (
      .s_axi_aclk (s_axi_aclk), .s_axi_aresetn (s_axi_aresetn),
      .awvalid (awvalid), .wvalid (wvalid), .bready (bready), .arvalid (arvalid),
      .awaddr (awaddr), .araddr (araddr), .awsize (awsize), .arsize (arsize),
      .txwr_wait (txwr_wait), .rd_done (rd_done),
      .awready (awready), .wready (wready), .bvalid (bvalid), .arready (arready),
      .req (req.ctrl));

   txwr_packer txwr0 (
      .s_axi_aclk (s_axi_aclk), .s_axi_aresetn (s_axi_aresetn),
      .wdata (wdata), .wstrb (wstrb), .req (req.wr),
      .txwr_access (txwr_access), .txwr_packet (txwr_packet));

   txrd_packer txrd0 (
      .s_axi_aclk (s_axi_aclk), .s_axi_aresetn (s_axi_aresetn), .req (req.rd),
      .txrd_access (txrd_access), .txrd_packet (txrd_packet));

   rxrr_return rxrr0 (
      .s_axi_aclk (s_axi_aclk), .s_axi_aresetn (s_axi_aresetn),
      .rxrr_access (rxrr_access), .rxrr_packet (rxrr_packet), .rready (rready),
      .req (req.rd), .rvalid (rvalid), .rdata (rdata), .rd_done (rd_done));

endmodule

/* test/tb_clkgen.sv */
module tb_clkgen
#(
   parameter int period     = 40,
   parameter int rst_cycles = 3
)
(
   output logic s_axi_aclk,
   output logic s_axi_aresetn
);

   initial
   begin
      s_axi_aclk = 1'b0;
      forever
         #(period / 2) s_axi_aclk = ~s_axi_aclk;
   end

   // low over the first rst_cycles rising edges
   initial
   begin
      s_axi_aresetn = 1'b0;
      repeat (rst_cycles)
         @(negedge s_axi_aclk);
      s_axi_aresetn <= 1'b1; // released on a falling edge
   end

endmodule

/* test/esaxi_tb.sv */
`include "esaxi_defs.svh"

module esaxi_tb;

   localparam int wait_limit = 1000; // well past the read timeout

   // one axi transfer per row
   typedef struct {
      logic               rd;        // 0 write, 1 read
      esaxi_pkg::addr_t   addr;
      esaxi_pkg::size_t   size;
      esaxi_pkg::data_t   wdata;
      esaxi_pkg::strb_t   wstrb;
      int                 stall;     // cycles of txwr_wait high or rready low
      logic               respond;   // mesh answers the read
      esaxi_pkg::data_t   rsp_data;  // data field of the response packet
      esaxi_pkg::packet_t exp_pkt;
      esaxi_pkg::data_t   exp_rdata;
   } entry_t;

   logic               s_axi_aclk, s_axi_aresetn;
   logic               awvalid, awready, wvalid, wready, bvalid, bready;
   logic               arvalid, arready, rvalid, rready;
   logic               txwr_access, txwr_wait, txrd_access, rxrr_access;
   esaxi_pkg::addr_t   awaddr, araddr;
   esaxi_pkg::size_t   awsize, arsize;
   esaxi_pkg::data_t   wdata, rdata;
   esaxi_pkg::strb_t   wstrb;
   esaxi_pkg::packet_t txwr_packet, txrd_packet, rxrr_packet;
   entry_t             tbl[$];
   logic [31:0]        rng;          // responder delay state

   tb_clkgen #(.period(40), .rst_cycles(3)) clk0 (.s_axi_aclk, .s_axi_aresetn);

   esaxi dut0 (.*);

   // ########################################
   // helpers
   // ########################################

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   // packs write, datamode, ctrlmode, dstaddr, data and srcaddr from lsb up
   function automatic esaxi_pkg::packet_t make_packet(input esaxi_pkg::addr_t src,
      input esaxi_pkg::data_t data, input esaxi_pkg::addr_t dst, input logic [1:0] mode,
      input logic wr);
      return {src, data, dst, 5'b00000, mode, wr};
   endfunction

   task automatic stop_failed();
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic abort_run(input string why);
      $display("** Error @ %0t: %s", $time, why);
      stop_failed();
   endtask

   task automatic check_bit(input string name, input logic act, input logic exp);
      if (act !== exp)
      begin
         $display("** Error @ %0t: %s = %b, expected %b", $time, name, act, exp);
         stop_failed();
      end
   endtask

   task automatic check_data(input string name, input esaxi_pkg::data_t act,
      input esaxi_pkg::data_t exp);
      if (act !== exp)
      begin
         $display("** Error @ %0t: %s = %h, expected %h", $time, name, act, exp);
         stop_failed();
      end
   endtask

   task automatic check_packet(input string name, input esaxi_pkg::packet_t act,
      input esaxi_pkg::packet_t exp);
      if (act !== exp)
      begin
         $display("** Error @ %0t: %s = %h, expected %h", $time, name, act, exp);
         stop_failed();
      end
   endtask

   function automatic logic level_of(input string name);
      case (name)
         "awready":       return awready;
         "wready":        return wready;
         "arready":       return arready;
         "rvalid":        return rvalid;
         "s_axi_aresetn": return s_axi_aresetn;
         default:         return 1'bx;
      endcase
   endfunction

   // polls on falling edges
   // cycles counts the edges waited
   task automatic wait_high(input string name, output int cycles);
      cycles = 0;
      while (level_of(name) !== 1'b1)
      begin
         @(negedge s_axi_aclk);
         cycles++;
         if (cycles > wait_limit)
            abort_run({name, " never went high"});
      end
   endtask

   // ########################################
   // transfers
   // ########################################

   task automatic run_write(input entry_t e);
      int cycles;
      awaddr    = e.addr;
      awsize    = e.size;
      awvalid   = 1'b1;
      wdata     = e.wdata;
      wstrb     = e.wstrb;
      wvalid    = 1'b1;
      txwr_wait = (e.stall > 0); // mesh busy
      wait_high("awready", cycles);
      @(negedge s_axi_aclk);     // aw taken
      awvalid = 1'b0;
      check_bit("awready", awready, 1'b0);
      repeat (e.stall)
      begin
         @(negedge s_axi_aclk);
         check_bit("wready", wready, 1'b0);
         check_bit("txwr_access", txwr_access, 1'b0);
      end
      txwr_wait = 1'b0;
      wait_high("wready", cycles);
      check_bit("bvalid", bvalid, 1'b0);
      @(negedge s_axi_aclk);     // w taken
      wvalid = 1'b0;
      check_bit("wready", wready, 1'b0);
      check_bit("bvalid", bvalid, 1'b1);
      check_bit("txwr_access", txwr_access, 1'b0);
      @(negedge s_axi_aclk);
      check_bit("txwr_access", txwr_access, 1'b1);
      check_packet("txwr_packet", txwr_packet, e.exp_pkt);
      @(negedge s_axi_aclk);
      check_bit("txwr_access", txwr_access, 1'b0); // one packet only
      check_bit("bvalid", bvalid, 1'b1);           // still waiting on bready
      bready = 1'b1;
      @(negedge s_axi_aclk);
      bready = 1'b0;
      check_bit("bvalid", bvalid, 1'b0);
      check_bit("awready", awready, 1'b1);
   endtask

   task automatic run_read(input entry_t e);
      int cycles;
      araddr  = e.addr;
      arsize  = e.size;
      arvalid = 1'b1;
      wait_high("arready", cycles);
      @(negedge s_axi_aclk);   // ar taken
      arvalid = 1'b0;
      check_bit("arready", arready, 1'b0);
      check_bit("txrd_access", txrd_access, 1'b0);
      @(negedge s_axi_aclk);
      check_bit("txrd_access", txrd_access, 1'b1);
      check_packet("txrd_packet", txrd_packet, e.exp_pkt);
      if (e.respond)
      begin
         // mesh responder model
         rng = xorshift(rng);
         repeat (1 + rng[1:0])
         begin
            @(negedge s_axi_aclk);
            check_bit("txrd_access", txrd_access, 1'b0);
            check_bit("rvalid", rvalid, 1'b0);
         end
         rxrr_packet = make_packet(e.addr, e.rsp_data, 32'h999d_0000, e.size[1:0], 1'b1);
         rxrr_access = 1'b1;
         @(negedge s_axi_aclk);
         rxrr_access = 1'b0;
      end
      else
      begin
         wait_high("rvalid", cycles); // silent mesh lets the counter run out
         if (cycles < (1 << `ESAXI_TW) - 4)
            abort_run("read timeout fired too early");
      end
      check_bit("rvalid", rvalid, 1'b1);
      check_data("rdata", rdata, e.exp_rdata);
      repeat (e.stall)
      begin
         @(negedge s_axi_aclk);
         check_bit("rvalid", rvalid, 1'b1); // back-pressure
         check_data("rdata", rdata, e.exp_rdata);
      end
      rready = 1'b1;
      @(negedge s_axi_aclk);
      rready = 1'b0;
      check_bit("rvalid", rvalid, 1'b0);
      check_bit("arready", arready, 1'b0); // re-arms a cycle later
      @(negedge s_axi_aclk);
      check_bit("arready", arready, 1'b1);
   endtask

   // ########################################
   // main sequence
   // ########################################

   initial
   begin
      int cycles;
      awaddr      = '0;
      awsize      = '0;
      awvalid     = 1'b0;
      wdata       = '0;
      wstrb       = '0;
      wvalid      = 1'b0;
      bready      = 1'b0;
      araddr      = '0;
      arsize      = '0;
      arvalid     = 1'b0;
      rready      = 1'b0;
      txwr_wait   = 1'b0;
      rxrr_access = 1'b0;
      rxrr_packet = '0;
      rng         = 32'd75097;

      // rd, addr, size, wdata, wstrb, stall, respond, rsp_data, packet, rdata
      tbl.push_back('{1'b0, 32'h8000_1003, 3'd2, 32'h1122_3344, 4'b1111, 0, 1'b0, '0,
         make_packet('0, 32'h1122_3344, 32'h8000_1000, 2'd2, 1'b1), '0});
      tbl.push_back('{1'b0, 32'h8000_2006, 3'd0, 32'haabb_ccdd, 4'b0010, 0, 1'b0, '0,
         make_packet('0, 32'h00aa_bbcc, 32'h8000_2005, 2'd0, 1'b1), '0});
      tbl.push_back('{1'b0, 32'h8000_2008, 3'd0, 32'h1234_5678, 4'b0100, 0, 1'b0, '0,
         make_packet('0, 32'h0000_1234, 32'h8000_200a, 2'd0, 1'b1), '0});
      tbl.push_back('{1'b0, 32'h8000_200c, 3'd0, 32'hcafe_f00d, 4'b1000, 0, 1'b0, '0,
         make_packet('0, 32'h0000_00ca, 32'h8000_200f, 2'd0, 1'b1), '0});
      tbl.push_back('{1'b0, 32'h8000_3010, 3'd1, 32'hbeef_0000, 4'b1100, 0, 1'b0, '0,
         make_packet('0, 32'h0000_beef, 32'h8000_3012, 2'd1, 1'b1), '0});
      tbl.push_back('{1'b1, 32'h9000_0040, 3'd2, '0, '0, 3, 1'b1, 32'h0bad_cafe,
         make_packet(32'h999d_0000, '0, 32'h9000_0040, 2'd2, 1'b0), 32'h0bad_cafe});
      tbl.push_back('{1'b1, 32'h9000_0041, 3'd0, '0, '0, 4, 1'b1, 32'h1234_56a5,
         make_packet(32'h999d_0000, '0, 32'h9000_0041, 2'd0, 1'b0), 32'ha5a5_a5a5});
      tbl.push_back('{1'b1, 32'h9000_0042, 3'd1, '0, '0, 2, 1'b1, 32'h5555_c3d2,
         make_packet(32'h999d_0000, '0, 32'h9000_0042, 2'd1, 1'b0), 32'hc3d2_c3d2});
      tbl.push_back('{1'b1, 32'h9000_0080, 3'd2, '0, '0, 1, 1'b0, '0,
         make_packet(32'h999d_0000, '0, 32'h9000_0080, 2'd2, 1'b0), 32'hdead_beef});
      tbl.push_back('{1'b1, 32'h9000_0084, 3'd2, '0, '0, 0, 1'b1, 32'h600d_f00d,
         make_packet(32'h999d_0000, '0, 32'h9000_0084, 2'd2, 1'b0), 32'h600d_f00d});
      tbl.push_back('{1'b0, 32'h8000_4000, 3'd2, 32'h7777_8888, 4'b1111, 6, 1'b0, '0,
         make_packet('0, 32'h7777_8888, 32'h8000_4000, 2'd2, 1'b1), '0});

      wait_high("s_axi_aresetn", cycles);
      check_bit("awready", awready, 1'b1);
      check_bit("arready", arready, 1'b1); // up one cycle out of reset
      check_bit("wready", wready, 1'b0);
      check_bit("bvalid", bvalid, 1'b0);
      check_bit("rvalid", rvalid, 1'b0);
      check_bit("txwr_access", txwr_access, 1'b0);
      check_bit("txrd_access", txrd_access, 1'b0);

      foreach (tbl[i])
      begin
         if (tbl[i].rd)
            run_read(tbl[i]);
         else
            run_write(tbl[i]);
         @(negedge s_axi_aclk); // idle gap
      end

      $display("Simulation completed successfully");
      $finish;
   end

endmodule

/* list.f */
+incdir+rtl
rtl/esaxi_pkg.sv
rtl/esaxi_req_if.sv
rtl/esaxi_ctrl.sv
rtl/txwr_packer.sv
rtl/txrd_packer.sv
rtl/rxrr_return.sv
rtl/esaxi.sv
test/tb_clkgen.sv
test/esaxi_tb.sv

/* Bender.yml */
package:
  name: esaxi

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/esaxi_pkg.sv
      - rtl/esaxi_req_if.sv
      - rtl/esaxi_ctrl.sv
      - rtl/txwr_packer.sv
      - rtl/txrd_packer.sv
      - rtl/rxrr_return.sv
      - rtl/esaxi.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/tb_clkgen.sv
      - test/esaxi_tb.sv
